//--- rtl/bus_pkg.sv
package bus_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // axi response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // address map
  localparam logic [ADDR_W-1:0] CLINT_MTIME_LO = 32'h0200_BFF8;
  localparam logic [ADDR_W-1:0] CLINT_MTIME_HI = 32'h0200_BFFC;
  localparam logic [ADDR_W-1:0] UART_TX_ADDR   = 32'h1000_0000;

  // serial timing, clocks per bit
  localparam int UART_DIV   = 16;
  localparam int UART_DIV_W = $clog2(UART_DIV);

  // decoder targets
  typedef enum logic [1:0] {
    TGT_MEM,
    TGT_CLINT,
    TGT_UART
  } target_e;

endpackage

//--- rtl/axil_if.sv
`timescale 1ns/1ps

interface axil_if;
  import bus_pkg::*;

  // read address and read data
  logic [ADDR_W-1:0] araddr;
  logic              arvalid;
  logic              arready;
  logic [DATA_W-1:0] rdata;
  logic [1:0]        rresp;
  logic              rvalid;
  logic              rready;

  // write address, write data, write response
  logic [ADDR_W-1:0] awaddr;
  logic              awvalid;
  logic              awready;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic              wvalid;
  logic              wready;
  logic [1:0]        bresp;
  logic              bvalid;
  logic              bready;

  modport master (
    output araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
    input  arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
  );

  modport slave (
    input  araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
    output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
  );

  modport rd_master (output araddr, arvalid, rready, input arready, rdata, rresp, rvalid);

  modport rd_slave (input araddr, arvalid, rready, output arready, rdata, rresp, rvalid);

endinterface

//--- rtl/read_arbiter.sv
`timescale 1ns/1ps

module read_arbiter (
  input  logic      clk,
  input  logic      rst,
  axil_if.rd_slave  ifu_i,
  axil_if.rd_slave  lsu_i,
  axil_if.rd_master arb_o
);

  // grant held from request until the read data returns
  logic busy;
  logic owner_lsu;
  logic ar_sent;
  logic fwd_ar;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= 1'b0;
      owner_lsu <= 1'b0;
      ar_sent   <= 1'b0;
    end else if (!busy) begin
      ar_sent <= 1'b0;
      // lsu wins, a pending load stalls the pipeline
      if (lsu_i.arvalid) begin
        busy      <= 1'b1;
        owner_lsu <= 1'b1;
      end else if (ifu_i.arvalid) begin
        busy      <= 1'b1;
        owner_lsu <= 1'b0;
      end
    end else begin
      if (arb_o.arvalid && arb_o.arready) begin
        ar_sent <= 1'b1;
      end
      if (arb_o.rvalid && arb_o.rready) begin
        busy    <= 1'b0;
        ar_sent <= 1'b0;
      end
    end
  end

  // only one address per grant goes out
  assign fwd_ar = busy && !ar_sent;

  assign arb_o.araddr  = owner_lsu ? lsu_i.araddr : ifu_i.araddr;
  assign arb_o.arvalid = fwd_ar && (owner_lsu ? lsu_i.arvalid : ifu_i.arvalid);
  assign lsu_i.arready = fwd_ar && owner_lsu && arb_o.arready;
  assign ifu_i.arready = fwd_ar && !owner_lsu && arb_o.arready;

  // response steered back to the owner only
  assign arb_o.rready = busy && (owner_lsu ? lsu_i.rready : ifu_i.rready);

  assign lsu_i.rdata  = arb_o.rdata;
  assign lsu_i.rresp  = arb_o.rresp;
  assign lsu_i.rvalid = busy && owner_lsu && arb_o.rvalid;

  assign ifu_i.rdata  = arb_o.rdata;
  assign ifu_i.rresp  = arb_o.rresp;
  assign ifu_i.rvalid = busy && !owner_lsu && arb_o.rvalid;

endmodule

//--- rtl/addr_decoder.sv
`timescale 1ns/1ps

module addr_decoder (
  input  logic                       clk,
  input  logic                       rst,
  axil_if.rd_slave                   rd_i,
  axil_if.slave                      wr_i,
  axil_if.rd_master                  clint_o,
  axil_if.master                     uart_o,
  output logic [bus_pkg::ADDR_W-1:0] m_araddr_o,
  output logic                       m_arvalid_o,
  input  logic                       m_arready_i,
  input  logic [bus_pkg::DATA_W-1:0] m_rdata_i,
  input  logic [1:0]                 m_rresp_i,
  input  logic                       m_rvalid_i,
  output logic                       m_rready_o,
  output logic [bus_pkg::ADDR_W-1:0] m_awaddr_o,
  output logic                       m_awvalid_o,
  input  logic                       m_awready_i,
  output logic [bus_pkg::DATA_W-1:0] m_wdata_o,
  output logic [bus_pkg::STRB_W-1:0] m_wstrb_o,
  output logic                       m_wvalid_o,
  input  logic                       m_wready_i,
  input  logic [1:0]                 m_bresp_i,
  input  logic                       m_bvalid_i,
  output logic                       m_bready_o
);
  import bus_pkg::*;

  function automatic target_e decode(input logic [ADDR_W-1:0] addr);
    // both mtime words share one 8-byte window
    if (addr[ADDR_W-1:3] == CLINT_MTIME_LO[ADDR_W-1:3]) begin
      return TGT_CLINT;
    end
    if (addr == UART_TX_ADDR) begin
      return TGT_UART;
    end
    return TGT_MEM;
  endfunction

  // read side
  target_e rd_tgt;
  target_e rd_tgt_q;
  logic    rd_busy;
  logic    ar_open;

  assign rd_tgt  = decode(rd_i.araddr);
  assign ar_open = rd_i.arvalid && !rd_busy;

  assign m_araddr_o      = rd_i.araddr;
  assign clint_o.araddr  = rd_i.araddr;
  assign uart_o.araddr   = rd_i.araddr;
  assign m_arvalid_o     = ar_open && (rd_tgt == TGT_MEM);
  assign clint_o.arvalid = ar_open && (rd_tgt == TGT_CLINT);
  assign uart_o.arvalid  = ar_open && (rd_tgt == TGT_UART);
  assign rd_i.arready    = !rd_busy && ((rd_tgt == TGT_CLINT) ? clint_o.arready :
                                        (rd_tgt == TGT_UART)  ? uart_o.arready  :
                                                                m_arready_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_busy <= 1'b0;
    end else if (rd_i.arvalid && rd_i.arready) begin
      rd_busy <= 1'b1;
    end else if (rd_i.rvalid && rd_i.rready) begin
      rd_busy <= 1'b0;
    end
  end

  // target held for routing r
  always_ff @(posedge clk) begin
    if (rd_i.arvalid && rd_i.arready) begin
      rd_tgt_q <= rd_tgt;
    end
  end

  assign m_rready_o     = rd_busy && (rd_tgt_q == TGT_MEM) && rd_i.rready;
  assign clint_o.rready = rd_busy && (rd_tgt_q == TGT_CLINT) && rd_i.rready;
  assign uart_o.rready  = rd_busy && (rd_tgt_q == TGT_UART) && rd_i.rready;

  always_comb begin
    case (rd_tgt_q)
      TGT_CLINT: begin
        rd_i.rdata  = clint_o.rdata;
        rd_i.rresp  = clint_o.rresp;
        rd_i.rvalid = rd_busy && clint_o.rvalid;
      end
      TGT_UART: begin
        rd_i.rdata  = uart_o.rdata;
        rd_i.rresp  = uart_o.rresp;
        rd_i.rvalid = rd_busy && uart_o.rvalid;
      end
      default: begin
        rd_i.rdata  = m_rdata_i;
        rd_i.rresp  = m_rresp_i;
        rd_i.rvalid = rd_busy && m_rvalid_i;
      end
    endcase
  end

  // write side, target latched once aw and w are both offered
  target_e wr_tgt_q;
  logic    wr_act;
  logic    aw_done;
  logic    w_done;
  logic    aw_open;
  logic    w_open;

  assign aw_open = wr_act && !aw_done;
  assign w_open  = wr_act && !w_done;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_act  <= 1'b0;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else if (!wr_act) begin
      wr_act <= wr_i.awvalid && wr_i.wvalid;
    end else if (wr_i.bvalid && wr_i.bready) begin
      wr_act  <= 1'b0;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      aw_done <= aw_done || (wr_i.awvalid && wr_i.awready);
      w_done  <= w_done || (wr_i.wvalid && wr_i.wready);
    end
  end

  always_ff @(posedge clk) begin
    if (!wr_act) begin
      wr_tgt_q <= decode(wr_i.awaddr);
    end
  end

  assign m_awaddr_o    = wr_i.awaddr;
  assign m_wdata_o     = wr_i.wdata;
  assign m_wstrb_o     = wr_i.wstrb;
  assign uart_o.awaddr = wr_i.awaddr;
  assign uart_o.wdata  = wr_i.wdata;
  assign uart_o.wstrb  = wr_i.wstrb;

  assign m_awvalid_o    = aw_open && (wr_tgt_q == TGT_MEM) && wr_i.awvalid;
  assign m_wvalid_o     = w_open && (wr_tgt_q == TGT_MEM) && wr_i.wvalid;
  assign uart_o.awvalid = aw_open && (wr_tgt_q == TGT_UART) && wr_i.awvalid;
  assign uart_o.wvalid  = w_open && (wr_tgt_q == TGT_UART) && wr_i.wvalid;
  assign m_bready_o     = wr_act && (wr_tgt_q == TGT_MEM) && wr_i.bready;
  assign uart_o.bready  = wr_act && (wr_tgt_q == TGT_UART) && wr_i.bready;

  // clint is read-only, the decoder answers its writes
  always_comb begin
    case (wr_tgt_q)
      TGT_CLINT: begin
        wr_i.awready = aw_open;
        wr_i.wready  = w_open;
        wr_i.bresp   = RESP_SLVERR;
        wr_i.bvalid  = wr_act && aw_done && w_done;
      end
      TGT_UART: begin
        wr_i.awready = aw_open && uart_o.awready;
        wr_i.wready  = w_open && uart_o.wready;
        wr_i.bresp   = uart_o.bresp;
        wr_i.bvalid  = wr_act && uart_o.bvalid;
      end
      default: begin
        wr_i.awready = aw_open && m_awready_i;
        wr_i.wready  = w_open && m_wready_i;
        wr_i.bresp   = m_bresp_i;
        wr_i.bvalid  = wr_act && m_bvalid_i;
      end
    endcase
  end

  // reads never travel on the lsu write link
  assign wr_i.arready = 1'b0;
  assign wr_i.rdata   = '0;
  assign wr_i.rresp   = RESP_OKAY;
  assign wr_i.rvalid  = 1'b0;

endmodule

//--- rtl/clint_timer.sv
`timescale 1ns/1ps

module clint_timer (
  input  logic     clk,
  input  logic     rst,
  axil_if.rd_slave bus_i
);
  import bus_pkg::*;

  logic [63:0]       mtime;
  logic [DATA_W-1:0] rdata_q;
  logic              rvalid_q;
  logic              ar_fire;

  assign ar_fire = bus_i.arvalid && bus_i.arready;

  // free-running cycle counter
  always_ff @(posedge clk) begin
    if (rst) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid_q <= 1'b0;
    end else if (ar_fire) begin
      rvalid_q <= 1'b1;
    end else if (rvalid_q && bus_i.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  // word picked by address bit 2, sampled at the handshake
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      rdata_q <= bus_i.araddr[2] ? mtime[63:32] : mtime[31:0];
    end
  end

  assign bus_i.arready = 1'b1;
  assign bus_i.rdata   = rdata_q;
  assign bus_i.rresp   = RESP_OKAY;
  assign bus_i.rvalid  = rvalid_q;

endmodule

//--- rtl/uart_tx_port.sv
`timescale 1ns/1ps

module uart_tx_port (
  input  logic  clk,
  input  logic  rst,
  axil_if.slave bus_i,
  output logic  tx_o
);
  import bus_pkg::*;

  logic                  busy;
  logic [8:0]            shreg;
  logic [3:0]            bit_cnt;
  logic [UART_DIV_W-1:0] div_cnt;
  logic                  bit_end;
  logic                  accept;
  logic                  bvalid_q;
  logic                  rvalid_q;

  // aw and w taken together, only between frames
  assign accept        = !busy && !bvalid_q && bus_i.awvalid && bus_i.wvalid;
  assign bus_i.awready = accept;
  assign bus_i.wready  = accept;
  assign bit_end       = (div_cnt == UART_DIV_W'(UART_DIV - 1));

  // bit 0 is start, 1..8 data, 9 stop
  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      bit_cnt <= '0;
      div_cnt <= '0;
      tx_o    <= 1'b1;
    end else if (accept) begin
      busy    <= 1'b1;
      bit_cnt <= '0;
      div_cnt <= '0;
      tx_o    <= 1'b0;
    end else if (busy) begin
      if (bit_end) begin
        div_cnt <= '0;
        if (bit_cnt == 4'd9) begin
          busy <= 1'b0;
        end else begin
          tx_o    <= shreg[0];
          bit_cnt <= bit_cnt + 4'd1;
        end
      end else begin
        div_cnt <= div_cnt + UART_DIV_W'(1);
      end
    end
  end

  // data lsb first, stop bit shifted in behind it
  always_ff @(posedge clk) begin
    if (accept) begin
      shreg <= {1'b1, bus_i.wdata[7:0]};
    end else if (busy && bit_end) begin
      shreg <= {1'b1, shreg[8:1]};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (accept) begin
        bvalid_q <= 1'b1;
      end else if (bus_i.bready) begin
        bvalid_q <= 1'b0;
      end
      if (bus_i.arvalid && bus_i.arready) begin
        rvalid_q <= 1'b1;
      end else if (bus_i.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  assign bus_i.bresp   = RESP_OKAY;
  assign bus_i.bvalid  = bvalid_q;

  // transmit only, reads are refused
  assign bus_i.arready = !rvalid_q;
  assign bus_i.rdata   = '0;
  assign bus_i.rresp   = RESP_SLVERR;
  assign bus_i.rvalid  = rvalid_q;

endmodule

//--- rtl/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [bus_pkg::ADDR_W-1:0] ifu_araddr_i,
  input  logic                       ifu_arvalid_i,
  output logic                       ifu_arready_o,
  output logic [bus_pkg::DATA_W-1:0] ifu_rdata_o,
  output logic [1:0]                 ifu_rresp_o,
  output logic                       ifu_rvalid_o,
  input  logic                       ifu_rready_i,
  input  logic [bus_pkg::ADDR_W-1:0] lsu_araddr_i,
  input  logic                       lsu_arvalid_i,
  output logic                       lsu_arready_o,
  output logic [bus_pkg::DATA_W-1:0] lsu_rdata_o,
  output logic [1:0]                 lsu_rresp_o,
  output logic                       lsu_rvalid_o,
  input  logic                       lsu_rready_i,
  input  logic [bus_pkg::ADDR_W-1:0] lsu_awaddr_i,
  input  logic                       lsu_awvalid_i,
  output logic                       lsu_awready_o,
  input  logic [bus_pkg::DATA_W-1:0] lsu_wdata_i,
  input  logic [bus_pkg::STRB_W-1:0] lsu_wstrb_i,
  input  logic                       lsu_wvalid_i,
  output logic                       lsu_wready_o,
  output logic [1:0]                 lsu_bresp_o,
  output logic                       lsu_bvalid_o,
  input  logic                       lsu_bready_i,
  output logic [bus_pkg::ADDR_W-1:0] m_araddr_o,
  output logic                       m_arvalid_o,
  input  logic                       m_arready_i,
  input  logic [bus_pkg::DATA_W-1:0] m_rdata_i,
  input  logic [1:0]                 m_rresp_i,
  input  logic                       m_rvalid_i,
  output logic                       m_rready_o,
  output logic [bus_pkg::ADDR_W-1:0] m_awaddr_o,
  output logic                       m_awvalid_o,
  input  logic                       m_awready_i,
  output logic [bus_pkg::DATA_W-1:0] m_wdata_o,
  output logic [bus_pkg::STRB_W-1:0] m_wstrb_o,
  output logic                       m_wvalid_o,
  input  logic                       m_wready_i,
  input  logic [1:0]                 m_bresp_i,
  input  logic                       m_bvalid_i,
  output logic                       m_bready_o,
  output logic                       uart_tx_o
);

  axil_if ifu_bus ();
  axil_if lsu_rd_bus ();
  axil_if arb_bus ();
  axil_if lsu_wr_bus ();
  axil_if clint_bus ();
  axil_if uart_bus ();

  // ifu read port
  assign ifu_bus.araddr  = ifu_araddr_i;
  assign ifu_bus.arvalid = ifu_arvalid_i;
  assign ifu_bus.rready  = ifu_rready_i;
  assign ifu_arready_o   = ifu_bus.arready;
  assign ifu_rdata_o     = ifu_bus.rdata;
  assign ifu_rresp_o     = ifu_bus.rresp;
  assign ifu_rvalid_o    = ifu_bus.rvalid;

  // lsu load port
  assign lsu_rd_bus.araddr  = lsu_araddr_i;
  assign lsu_rd_bus.arvalid = lsu_arvalid_i;
  assign lsu_rd_bus.rready  = lsu_rready_i;
  assign lsu_arready_o      = lsu_rd_bus.arready;
  assign lsu_rdata_o        = lsu_rd_bus.rdata;
  assign lsu_rresp_o        = lsu_rd_bus.rresp;
  assign lsu_rvalid_o       = lsu_rd_bus.rvalid;

  // lsu store port
  assign lsu_wr_bus.awaddr  = lsu_awaddr_i;
  assign lsu_wr_bus.awvalid = lsu_awvalid_i;
  assign lsu_wr_bus.wdata   = lsu_wdata_i;
  assign lsu_wr_bus.wstrb   = lsu_wstrb_i;
  assign lsu_wr_bus.wvalid  = lsu_wvalid_i;
  assign lsu_wr_bus.bready  = lsu_bready_i;
  assign lsu_awready_o      = lsu_wr_bus.awready;
  assign lsu_wready_o       = lsu_wr_bus.wready;
  assign lsu_bresp_o        = lsu_wr_bus.bresp;
  assign lsu_bvalid_o       = lsu_wr_bus.bvalid;

  read_arbiter u_read_arbiter (
    .clk   (clk),
    .rst   (rst),
    .ifu_i (ifu_bus),
    .lsu_i (lsu_rd_bus),
    .arb_o (arb_bus)
  );

  addr_decoder u_addr_decoder (
    .clk         (clk),
    .rst         (rst),
    .rd_i        (arb_bus),
    .wr_i        (lsu_wr_bus),
    .clint_o     (clint_bus),
    .uart_o      (uart_bus),
    .m_araddr_o  (m_araddr_o),
    .m_arvalid_o (m_arvalid_o),
    .m_arready_i (m_arready_i),
    .m_rdata_i   (m_rdata_i),
    .m_rresp_i   (m_rresp_i),
    .m_rvalid_i  (m_rvalid_i),
    .m_rready_o  (m_rready_o),
    .m_awaddr_o  (m_awaddr_o),
    .m_awvalid_o (m_awvalid_o),
    .m_awready_i (m_awready_i),
    .m_wdata_o   (m_wdata_o),
    .m_wstrb_o   (m_wstrb_o),
    .m_wvalid_o  (m_wvalid_o),
    .m_wready_i  (m_wready_i),
    .m_bresp_i   (m_bresp_i),
    .m_bvalid_i  (m_bvalid_i),
    .m_bready_o  (m_bready_o)
  );

  clint_timer u_clint_timer (
    .clk   (clk),
    .rst   (rst),
    .bus_i (clint_bus)
  );

  uart_tx_port u_uart_tx_port (
    .clk   (clk),
    .rst   (rst),
    .bus_i (uart_bus),
    .tx_o  (uart_tx_o)
  );

endmodule

//--- sim/tb_soc_bus.sv
`timescale 1ns/1ps

module tb_soc_bus;
  import bus_pkg::*;

  localparam int TIMEOUT = 400;

  logic              clk;
  logic              rst;
  logic [ADDR_W-1:0] ifu_araddr_i;
  logic              ifu_arvalid_i;
  logic              ifu_arready_o;
  logic [DATA_W-1:0] ifu_rdata_o;
  logic [1:0]        ifu_rresp_o;
  logic              ifu_rvalid_o;
  logic              ifu_rready_i;
  logic [ADDR_W-1:0] lsu_araddr_i;
  logic              lsu_arvalid_i;
  logic              lsu_arready_o;
  logic [DATA_W-1:0] lsu_rdata_o;
  logic [1:0]        lsu_rresp_o;
  logic              lsu_rvalid_o;
  logic              lsu_rready_i;
  logic [ADDR_W-1:0] lsu_awaddr_i;
  logic              lsu_awvalid_i;
  logic              lsu_awready_o;
  logic [DATA_W-1:0] lsu_wdata_i;
  logic [STRB_W-1:0] lsu_wstrb_i;
  logic              lsu_wvalid_i;
  logic              lsu_wready_o;
  logic [1:0]        lsu_bresp_o;
  logic              lsu_bvalid_o;
  logic              lsu_bready_i;
  logic [ADDR_W-1:0] m_araddr_o;
  logic              m_arvalid_o;
  logic              m_arready_i;
  logic [DATA_W-1:0] m_rdata_i;
  logic [1:0]        m_rresp_i;
  logic              m_rvalid_i;
  logic              m_rready_o;
  logic [ADDR_W-1:0] m_awaddr_o;
  logic              m_awvalid_o;
  logic              m_awready_i;
  logic [DATA_W-1:0] m_wdata_o;
  logic [STRB_W-1:0] m_wstrb_o;
  logic              m_wvalid_o;
  logic              m_wready_i;
  logic [1:0]        m_bresp_i;
  logic              m_bvalid_i;
  logic              m_bready_o;
  logic              uart_tx_o;

  int                value_errors = 0;
  int                hold_errors = 0;
  int                timeouts = 0;
  int                clk_count = 0;
  logic [15:0]       lfsr_q = 16'd60859;
  logic [DATA_W-1:0] mem_q [logic [ADDR_W-1:0]];

  soc_bus_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // clocks since reset, equal to mtime when read at a falling edge
  always @(posedge clk) begin
    if (rst) begin
      clk_count = 0;
    end else begin
      clk_count = clk_count + 1;
    end
  end

  // x^16 + x^14 + x^13 + x^11, one step per bit
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
    // untouched words are a swizzle of their address
    if (mem_q.exists(addr)) begin
      return mem_q[addr];
    end
    return {addr[15:0], addr[31:16]} ^ 32'h6C3A_91E5;
  endfunction

  function automatic target_e route_of(input logic [ADDR_W-1:0] addr);
    if (addr == CLINT_MTIME_LO || addr == CLINT_MTIME_HI) begin
      return TGT_CLINT;
    end
    if (addr == UART_TX_ADDR) begin
      return TGT_UART;
    end
    return TGT_MEM;
  endfunction

  function automatic logic [1:0] exp_read_resp(input logic [ADDR_W-1:0] addr);
    return (route_of(addr) == TGT_UART) ? RESP_SLVERR : RESP_OKAY;
  endfunction

  function automatic logic [1:0] exp_write_resp(input logic [ADDR_W-1:0] addr);
    return (route_of(addr) == TGT_CLINT) ? RESP_SLVERR : RESP_OKAY;
  endfunction

  function automatic void check_val(input string what, input logic [DATA_W-1:0] got,
                                    input logic [DATA_W-1:0] exp);
    assert (got == exp) else begin
      value_errors++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endfunction

  function automatic void timed_out(input string what);
    timeouts++;
    $display("timeout at %0t: gave up waiting for %s", $time, what);
  endfunction

  function automatic void hold_broken(input string chan);
    hold_errors++;
    $display("ERROR at %0t: %s changed while valid waited for ready", $time, chan);
  endfunction

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #1;
    end
  endtask

  // payloads must hold while a source waits for ready
  assert property (@(posedge clk) disable iff (rst)
    (m_arvalid_o && !m_arready_i) |=> (m_arvalid_o && $stable(m_araddr_o)))
    else hold_broken("memory read address");
  assert property (@(posedge clk) disable iff (rst)
    (m_awvalid_o && !m_awready_i) |=> (m_awvalid_o && $stable(m_awaddr_o)))
    else hold_broken("memory write address");
  assert property (@(posedge clk) disable iff (rst)
    (m_wvalid_o && !m_wready_i) |=> (m_wvalid_o && $stable({m_wdata_o, m_wstrb_o})))
    else hold_broken("memory write data");
  assert property (@(posedge clk) disable iff (rst)
    (ifu_rvalid_o && !ifu_rready_i) |=> (ifu_rvalid_o && $stable({ifu_rdata_o, ifu_rresp_o})))
    else hold_broken("ifu read data");
  assert property (@(posedge clk) disable iff (rst)
    (lsu_rvalid_o && !lsu_rready_i) |=> (lsu_rvalid_o && $stable({lsu_rdata_o, lsu_rresp_o})))
    else hold_broken("lsu read data");
  assert property (@(posedge clk) disable iff (rst)
    (lsu_bvalid_o && !lsu_bready_i) |=> (lsu_bvalid_o && $stable(lsu_bresp_o)))
    else hold_broken("lsu write response");

  // memory read side with random ready and data delays
  initial begin : mem_read_model
    logic [ADDR_W-1:0] addr;
    int                delay;
    int                n;
    logic              fire;
    m_arready_i = 1'b0;
    m_rvalid_i  = 1'b0;
    m_rdata_i   = '0;
    m_rresp_i   = RESP_OKAY;
    forever begin
      @(negedge clk);
      if (!rst && m_arvalid_o) begin
        addr  = m_araddr_o;
        delay = int'(lfsr_bits(2));
        idle(delay + 1);
        m_arready_i = 1'b1;
        idle(1);
        m_arready_i = 1'b0;
        delay = int'(lfsr_bits(2));
        idle(delay);
        m_rdata_i  = mem_word(addr);
        m_rresp_i  = RESP_OKAY;
        m_rvalid_i = 1'b1;
        n    = 0;
        fire = 1'b0;
        while (!fire && n < TIMEOUT) begin
          @(negedge clk);
          fire = m_rready_o;
          n++;
        end
        if (!fire) begin
          timed_out("memory read data to be taken");
        end
        idle(1);
        m_rvalid_i = 1'b0;
      end
    end
  end

  // strobed bytes merge into the sparse array
  initial begin : mem_write_model
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] word;
    logic [STRB_W-1:0] strb;
    int                delay;
    int                n;
    logic              fire;
    m_awready_i = 1'b0;
    m_wready_i  = 1'b0;
    m_bvalid_i  = 1'b0;
    m_bresp_i   = RESP_OKAY;
    forever begin
      @(negedge clk);
      if (!rst && m_awvalid_o && m_wvalid_o) begin
        addr  = m_awaddr_o;
        data  = m_wdata_o;
        strb  = m_wstrb_o;
        delay = int'(lfsr_bits(2));
        idle(delay + 1);
        m_awready_i = 1'b1;
        m_wready_i  = 1'b1;
        idle(1);
        m_awready_i = 1'b0;
        m_wready_i  = 1'b0;
        word = mem_word(addr);
        for (int i = 0; i < STRB_W; i++) begin
          if (strb[i]) begin
            word[8*i +: 8] = data[8*i +: 8];
          end
        end
        mem_q[addr] = word;
        delay = int'(lfsr_bits(2));
        idle(delay);
        m_bvalid_i = 1'b1;
        n    = 0;
        fire = 1'b0;
        while (!fire && n < TIMEOUT) begin
          @(negedge clk);
          fire = m_bready_o;
          n++;
        end
        if (!fire) begin
          timed_out("memory write response to be taken");
        end
        idle(1);
        m_bvalid_i = 1'b0;
      end
    end
  end

  // one read on the ifu or lsu port with rready toggled at random
  task automatic bus_read(input logic use_lsu, input logic [ADDR_W-1:0] addr,
                          output logic [DATA_W-1:0] data, output logic [1:0] resp,
                          output int hs_cycle, output int done_cycle);
    int   n;
    logic fire;
    logic rdy;
    if (use_lsu) begin
      lsu_araddr_i  = addr;
      lsu_arvalid_i = 1'b1;
    end else begin
      ifu_araddr_i  = addr;
      ifu_arvalid_i = 1'b1;
    end
    n        = 0;
    fire     = 1'b0;
    hs_cycle = 0;
    while (!fire && n < TIMEOUT) begin
      @(negedge clk);
      fire     = use_lsu ? lsu_arready_o : ifu_arready_o;
      hs_cycle = clk_count;
      n++;
      idle(1);
    end
    if (use_lsu) begin
      lsu_arvalid_i = 1'b0;
    end else begin
      ifu_arvalid_i = 1'b0;
    end
    if (!fire) begin
      timed_out(use_lsu ? "lsu read address" : "ifu read address");
    end
    n          = 0;
    fire       = 1'b0;
    data       = '0;
    resp       = '0;
    done_cycle = 0;
    while (!fire && n < TIMEOUT) begin
      rdy = lfsr_bits(1) != 0;
      if (use_lsu) begin
        lsu_rready_i = rdy;
      end else begin
        ifu_rready_i = rdy;
      end
      @(negedge clk);
      fire       = rdy && (use_lsu ? lsu_rvalid_o : ifu_rvalid_o);
      data       = use_lsu ? lsu_rdata_o : ifu_rdata_o;
      resp       = use_lsu ? lsu_rresp_o : ifu_rresp_o;
      done_cycle = clk_count;
      n++;
      idle(1);
    end
    if (use_lsu) begin
      lsu_rready_i = 1'b0;
    end else begin
      ifu_rready_i = 1'b0;
    end
    if (!fire) begin
      timed_out(use_lsu ? "lsu read data" : "ifu read data");
    end
  endtask

  task automatic lsu_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic [STRB_W-1:0] strb, output logic [1:0] resp,
                           output int hs_cycle);
    int   n;
    logic aw_fire;
    logic w_fire;
    logic aw_ok;
    logic w_ok;
    logic fire;
    lsu_awaddr_i  = addr;
    lsu_awvalid_i = 1'b1;
    lsu_wdata_i   = data;
    lsu_wstrb_i   = strb;
    lsu_wvalid_i  = 1'b1;
    n        = 0;
    aw_ok    = 1'b0;
    w_ok     = 1'b0;
    hs_cycle = 0;
    while (!(aw_ok && w_ok) && n < TIMEOUT) begin
      @(negedge clk);
      aw_fire = lsu_awvalid_i && lsu_awready_o;
      w_fire  = lsu_wvalid_i && lsu_wready_o;
      if (aw_fire) begin
        hs_cycle = clk_count;
      end
      n++;
      idle(1);
      if (aw_fire) begin
        aw_ok         = 1'b1;
        lsu_awvalid_i = 1'b0;
      end
      if (w_fire) begin
        w_ok         = 1'b1;
        lsu_wvalid_i = 1'b0;
      end
    end
    if (!(aw_ok && w_ok)) begin
      timed_out("lsu write address and data");
      lsu_awvalid_i = 1'b0;
      lsu_wvalid_i  = 1'b0;
    end
    n    = 0;
    fire = 1'b0;
    resp = '0;
    while (!fire && n < TIMEOUT) begin
      lsu_bready_i = lfsr_bits(1) != 0;
      @(negedge clk);
      fire = lsu_bready_i && lsu_bvalid_o;
      resp = lsu_bresp_o;
      n++;
      idle(1);
    end
    lsu_bready_i = 1'b0;
    if (!fire) begin
      timed_out("lsu write response");
    end
  endtask

  // samples each 8N1 bit in its middle
  task automatic check_uart_frame(input logic [7:0] data, output int start_cycle);
    int         n;
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    n     = 0;
    @(negedge clk);
    while (uart_tx_o && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    start_cycle = clk_count;
    if (uart_tx_o) begin
      timed_out("uart start bit");
    end else begin
      for (int i = 0; i < 10; i++) begin
        repeat ((i == 0) ? UART_DIV / 2 : UART_DIV) @(negedge clk);
        check_val($sformatf("uart frame bit %0d", i), 32'(uart_tx_o), 32'(frame[i]));
      end
    end
  endtask

  initial begin : stimulus
    logic [ADDR_W-1:0] a0;
    logic [ADDR_W-1:0] a1;
    logic [DATA_W-1:0] d0;
    logic [DATA_W-1:0] d1;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] mask;
    logic [DATA_W-1:0] exp;
    logic [STRB_W-1:0] strb;
    logic [1:0]        r0;
    logic [1:0]        r1;
    logic [7:0]        b0;
    logic [7:0]        b1;
    int                hs0;
    int                hs1;
    int                done0;
    int                done1;
    int                start0;
    int                start1;
    rst           = 1'b1;
    ifu_araddr_i  = '0;
    ifu_arvalid_i = 1'b0;
    ifu_rready_i  = 1'b0;
    lsu_araddr_i  = '0;
    lsu_arvalid_i = 1'b0;
    lsu_rready_i  = 1'b0;
    lsu_awaddr_i  = '0;
    lsu_awvalid_i = 1'b0;
    lsu_wdata_i   = '0;
    lsu_wstrb_i   = '0;
    lsu_wvalid_i  = 1'b0;
    lsu_bready_i  = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    idle(2);

    // single reads from each port
    a0 = 32'h8000_0000 | (lfsr_bits(12) << 2);
    a1 = 32'h8000_4000 | (lfsr_bits(12) << 2);
    mem_q[a0] = lfsr_bits(32);
    mem_q[a1] = lfsr_bits(32);
    bus_read(1'b0, a0, d0, r0, hs0, done0);
    check_val("ifu read data", d0, mem_word(a0));
    check_val("ifu read resp", 32'(r0), 32'(exp_read_resp(a0)));
    bus_read(1'b1, a1, d1, r1, hs1, done1);
    check_val("lsu read data", d1, mem_word(a1));
    check_val("lsu read resp", 32'(r1), 32'(exp_read_resp(a1)));

    // same-cycle requests with the lsu served first
    a0 = 32'h8001_0000 | (lfsr_bits(12) << 2);
    a1 = 32'h8001_4000 | (lfsr_bits(12) << 2);
    mem_q[a0] = lfsr_bits(32);
    mem_q[a1] = lfsr_bits(32);
    fork
      bus_read(1'b0, a0, d0, r0, hs0, done0);
      bus_read(1'b1, a1, d1, r1, hs1, done1);
    join
    check_val("ifu read data after contention", d0, mem_word(a0));
    check_val("lsu read data after contention", d1, mem_word(a1));
    assert (done1 < done0) else begin
      value_errors++;
      $display("ERROR at %0t: ifu response finished before the lsu response", $time);
    end

    // strobed store then load back
    a0    = 32'h8002_0000 | (lfsr_bits(12) << 2);
    wdata = lfsr_bits(32);
    strb  = 4'(lfsr_bits(4));
    for (int i = 0; i < STRB_W; i++) begin
      mask[8*i +: 8] = {8{strb[i]}};
    end
    exp = (mem_word(a0) & ~mask) | (wdata & mask);
    lsu_write(a0, wdata, strb, r0, hs0);
    check_val("memory write resp", 32'(r0), 32'(exp_write_resp(a0)));
    check_val("memory word after strobed write", mem_word(a0), exp);
    bus_read(1'b1, a0, d0, r0, hs0, done0);
    check_val("merged word read back", d0, exp);

    // mtime matches the clock count at the handshake
    bus_read(1'b1, CLINT_MTIME_LO, d0, r0, hs0, done0);
    check_val("mtime low word", d0, 32'(hs0));
    check_val("mtime read resp", 32'(r0), 32'(exp_read_resp(CLINT_MTIME_LO)));
    idle(int'(lfsr_bits(3)) + 1);
    bus_read(1'b1, CLINT_MTIME_LO, d0, r0, hs0, done0);
    check_val("mtime low word again", d0, 32'(hs0));
    bus_read(1'b1, CLINT_MTIME_HI, d0, r0, hs0, done0);
    check_val("mtime high word", d0, 32'h0);

    // two back-to-back uart bytes
    b0 = 8'(lfsr_bits(8));
    b1 = 8'(lfsr_bits(8));
    fork
      begin
        lsu_write(UART_TX_ADDR, {24'h0, b0}, 4'h1, r0, hs0);
        lsu_write(UART_TX_ADDR, {24'h0, b1}, 4'h1, r1, hs1);
      end
      begin
        check_uart_frame(b0, start0);
        check_uart_frame(b1, start1);
      end
    join
    check_val("first uart write resp", 32'(r0), 32'(exp_write_resp(UART_TX_ADDR)));
    check_val("second uart write resp", 32'(r1), 32'(exp_write_resp(UART_TX_ADDR)));
    assert (hs1 - start0 >= 10 * UART_DIV) else begin
      value_errors++;
      $display("ERROR at %0t: second uart write taken %0d cycles into the frame",
               $time, hs1 - start0);
    end

    // refused accesses
    bus_read(1'b1, UART_TX_ADDR, d0, r0, hs0, done0);
    check_val("uart read data", d0, 32'h0);
    check_val("uart read resp", 32'(r0), 32'(exp_read_resp(UART_TX_ADDR)));
    lsu_write(CLINT_MTIME_LO, lfsr_bits(32), 4'hF, r0, hs0);
    check_val("clint write resp", 32'(r0), 32'(exp_write_resp(CLINT_MTIME_LO)));

    idle(5);
    $display("tb_soc_bus: %0d value errors, %0d hold errors, %0d timeouts",
             value_errors, hold_errors, timeouts);
    if (value_errors + hold_errors + timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- vlog.f
rtl/bus_pkg.sv
rtl/axil_if.sv
rtl/read_arbiter.sv
rtl/addr_decoder.sv
rtl/clint_timer.sv
rtl/uart_tx_port.sv
rtl/soc_bus_top.sv
sim/tb_soc_bus.sv

//--- run_sim.sh
#!/bin/sh
# build and run the bus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_soc_bus -o tb_soc_bus

out=$(./obj_dir/tb_soc_bus)
echo "$out"

echo "$out" | grep -qF "*** TEST PASSED ***"
